// ==== Makefile ====
TOP := tb_dct_1d

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f dct_1d.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== dct_1d.f ====
+incdir+test
design/dct_pkg.sv
design/dct_rotator.sv
design/dct_butterfly_stage.sv
design/dct_even_odd_stage.sv
design/dct_rotate_stage.sv
design/dct_output_stage.sv
design/dct_1d.sv
test/tb_dct_1d.sv

// ==== design/dct_1d.sv ====
`timescale 1ns/1ps
`default_nettype none

// eight-point 1-D DCT, four register levels, one block per cycle
module dct_1d (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  dct_pkg::sample_vec_t  in_block,
  output logic                  out_valid,
  output dct_pkg::lane_vec_t    out_block
);

  localparam int EXT_W = dct_pkg::LANE_W - dct_pkg::SAMPLE_W;  // sign bits added

  dct_pkg::lane_vec_t in_lanes;  // widened input
  dct_pkg::lane_vec_t s1_block;
  dct_pkg::lane_vec_t s2_block;
  dct_pkg::lane_vec_t s3_block;
  logic               s1_valid;
  logic               s2_valid;
  logic               s3_valid;

  ////////////////////////////////////////
  // sign extension to lane width
  ////////////////////////////////////////
  assign in_lanes.x0 = {{EXT_W{in_block.x0[dct_pkg::SAMPLE_W-1]}}, in_block.x0};
  assign in_lanes.x1 = {{EXT_W{in_block.x1[dct_pkg::SAMPLE_W-1]}}, in_block.x1};
  assign in_lanes.x2 = {{EXT_W{in_block.x2[dct_pkg::SAMPLE_W-1]}}, in_block.x2};
  assign in_lanes.x3 = {{EXT_W{in_block.x3[dct_pkg::SAMPLE_W-1]}}, in_block.x3};
  assign in_lanes.x4 = {{EXT_W{in_block.x4[dct_pkg::SAMPLE_W-1]}}, in_block.x4};
  assign in_lanes.x5 = {{EXT_W{in_block.x5[dct_pkg::SAMPLE_W-1]}}, in_block.x5};
  assign in_lanes.x6 = {{EXT_W{in_block.x6[dct_pkg::SAMPLE_W-1]}}, in_block.x6};
  assign in_lanes.x7 = {{EXT_W{in_block.x7[dct_pkg::SAMPLE_W-1]}}, in_block.x7};

  ////////////////////////////////////////
  // stage chain
  ////////////////////////////////////////
  dct_butterfly_stage u_stage1 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_block  (in_lanes),
    .out_valid (s1_valid),
    .out_block (s1_block)
  );

  dct_even_odd_stage u_stage2 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (s1_valid),
    .in_block  (s1_block),
    .out_valid (s2_valid),
    .out_block (s2_block)
  );

  dct_rotate_stage u_stage3 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (s2_valid),
    .in_block  (s2_block),
    .out_valid (s3_valid),
    .out_block (s3_block)
  );

  dct_output_stage u_stage4 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (s3_valid),
    .in_block  (s3_block),
    .out_valid (out_valid),
    .out_block (out_block)
  );

endmodule

`default_nettype wire

// ==== design/dct_butterfly_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 1, mirror butterflies x_k +/- x_(7-k)
module dct_butterfly_stage (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  dct_pkg::lane_vec_t  in_block,
  output logic                out_valid,
  output dct_pkg::lane_vec_t  out_block
);

  ////////////////////////////////////////
  // valid pipe
  ////////////////////////////////////////
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;  // one cycle
    end
  end

  ////////////////////////////////////////
  // butterflies, loaded on valid only
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (in_valid) begin
      out_block.x0 <= in_block.x0 + in_block.x7;  // sums low half
      out_block.x1 <= in_block.x1 + in_block.x6;
      out_block.x2 <= in_block.x2 + in_block.x5;
      out_block.x3 <= in_block.x3 + in_block.x4;
      out_block.x4 <= in_block.x3 - in_block.x4;  // differences high half
      out_block.x5 <= in_block.x2 - in_block.x5;
      out_block.x6 <= in_block.x1 - in_block.x6;
      out_block.x7 <= in_block.x0 - in_block.x7;
    end
  end

  // valid must track input one cycle late once out of reset
  a_valid_delay: assert property (
    @(posedge aclk) disable iff (!rst_n)
    $past(rst_n) |-> (out_valid == $past(in_valid))
  ) else $error("stage 1 valid out of step with input");

endmodule

`default_nettype wire

// ==== design/dct_even_odd_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 2, even butterflies and sqrt(1/2) on the middle odd pair
module dct_even_odd_stage (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  dct_pkg::lane_vec_t  in_block,
  output logic                out_valid,
  output dct_pkg::lane_vec_t  out_block
);

  logic signed [dct_pkg::LANE_W-1:0] mid_diff;  // x6 - x5
  logic signed [dct_pkg::LANE_W-1:0] mid_sum;   // x6 + x5
  logic signed [dct_pkg::LANE_W-1:0] mid5;      // scaled lane 5
  logic signed [dct_pkg::LANE_W-1:0] mid6;      // scaled lane 6

  ////////////////////////////////////////
  // odd middle pair
  ////////////////////////////////////////
  assign mid_diff = in_block.x6 - in_block.x5;
  assign mid_sum  = in_block.x6 + in_block.x5;
  assign mid5     = dct_pkg::mul_coef(mid_diff, dct_pkg::C_PI_4);
  assign mid6     = dct_pkg::mul_coef(mid_sum, dct_pkg::C_PI_4);

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  ////////////////////////////////////////
  // register
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (in_valid) begin
      out_block.x0 <= in_block.x0 + in_block.x3;  // even sums
      out_block.x1 <= in_block.x1 + in_block.x2;
      out_block.x2 <= in_block.x1 - in_block.x2;  // even diffs
      out_block.x3 <= in_block.x0 - in_block.x3;
      out_block.x4 <= in_block.x4;                // odd ends pass
      out_block.x5 <= mid5;
      out_block.x6 <= mid6;
      out_block.x7 <= in_block.x7;
    end
  end

  a_valid_delay: assert property (
    @(posedge aclk) disable iff (!rst_n)
    $past(rst_n) |-> (out_valid == $past(in_valid))
  ) else $error("stage 2 valid out of step with input");

endmodule

`default_nettype wire

// ==== design/dct_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 4, pi/16 and 3pi/16 rotations on the odd lanes
module dct_output_stage (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  dct_pkg::lane_vec_t  in_block,
  output logic                out_valid,
  output dct_pkg::lane_vec_t  out_block
);

  logic signed [dct_pkg::LANE_W-1:0] r1_sum;   // lane 4
  logic signed [dct_pkg::LANE_W-1:0] r1_diff;  // lane 7
  logic signed [dct_pkg::LANE_W-1:0] r3_sum;   // lane 5
  logic signed [dct_pkg::LANE_W-1:0] r3_diff;  // lane 6

  ////////////////////////////////////////
  // rotations
  ////////////////////////////////////////
  dct_rotator #(
    .K0 (dct_pkg::S_PI_16_H),
    .K1 (dct_pkg::C_PI_16_H)
  ) u_rot_pi_16 (
    .a      (in_block.x4),
    .b      (in_block.x7),
    .y_sum  (r1_sum),
    .y_diff (r1_diff)
  );

  dct_rotator #(
    .K0 (dct_pkg::C_3PI_16_H),  // cosine first on this pair
    .K1 (dct_pkg::S_3PI_16_H)
  ) u_rot_3pi_16 (
    .a      (in_block.x5),
    .b      (in_block.x6),
    .y_sum  (r3_sum),
    .y_diff (r3_diff)
  );

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid) begin
      out_block.x0 <= in_block.x0;  // even half already final
      out_block.x1 <= in_block.x1;
      out_block.x2 <= in_block.x2;
      out_block.x3 <= in_block.x3;
      out_block.x4 <= r1_sum;
      out_block.x5 <= r3_sum;
      out_block.x6 <= r3_diff;
      out_block.x7 <= r1_diff;
    end
  end

  a_valid_delay: assert property (
    @(posedge aclk) disable iff (!rst_n)
    $past(rst_n) |-> (out_valid == $past(in_valid))
  ) else $error("stage 4 valid out of step with input");

endmodule

`default_nettype wire

// ==== design/dct_pkg.sv ====
`default_nettype none

package dct_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int SAMPLE_W  = 16;  // input sample
  localparam int LANE_W    = 24;  // internal and output lane, room for growth
  localparam int COEF_W    = 16;  // coefficient word
  localparam int COEF_FRAC = 14;  // Q1.14

  ////////////////////////////////////////
  // coefficients, Q1.14 rounded to nearest
  ////////////////////////////////////////
  localparam logic signed [COEF_W-1:0] C_PI_4     = 16'sd11585;  // cos(pi/4)
  localparam logic signed [COEF_W-1:0] C_PI_4_H   = 16'sd5793;   // cos(pi/4)/2
  localparam logic signed [COEF_W-1:0] S_PI_8_H   = 16'sd3135;   // sin(pi/8)/2
  localparam logic signed [COEF_W-1:0] C_PI_8_H   = 16'sd7568;   // cos(pi/8)/2
  localparam logic signed [COEF_W-1:0] S_PI_16_H  = 16'sd1598;   // sin(pi/16)/2
  localparam logic signed [COEF_W-1:0] C_PI_16_H  = 16'sd8035;   // cos(pi/16)/2
  localparam logic signed [COEF_W-1:0] S_3PI_16_H = 16'sd4551;   // sin(3pi/16)/2
  localparam logic signed [COEF_W-1:0] C_3PI_16_H = 16'sd6811;   // cos(3pi/16)/2

  ////////////////////////////////////////
  // block types
  ////////////////////////////////////////
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] x0;  // first sample, top bits
    logic signed [SAMPLE_W-1:0] x1;
    logic signed [SAMPLE_W-1:0] x2;
    logic signed [SAMPLE_W-1:0] x3;
    logic signed [SAMPLE_W-1:0] x4;
    logic signed [SAMPLE_W-1:0] x5;
    logic signed [SAMPLE_W-1:0] x6;
    logic signed [SAMPLE_W-1:0] x7;  // last sample, low bits
  } sample_vec_t;

  typedef struct packed {
    logic signed [LANE_W-1:0] x0;
    logic signed [LANE_W-1:0] x1;
    logic signed [LANE_W-1:0] x2;
    logic signed [LANE_W-1:0] x3;
    logic signed [LANE_W-1:0] x4;
    logic signed [LANE_W-1:0] x5;
    logic signed [LANE_W-1:0] x6;
    logic signed [LANE_W-1:0] x7;
  } lane_vec_t;

  // lane times coefficient, full product then floor by COEF_FRAC
  function automatic logic signed [LANE_W-1:0] mul_coef(
    input logic signed [LANE_W-1:0] a,
    input logic signed [COEF_W-1:0] k
  );
    logic signed [LANE_W+COEF_W-1:0] prod;
    logic signed [LANE_W+COEF_W-1:0] shifted;
    prod    = a * k;                // signed, no overflow at 40 bits
    shifted = prod >>> COEF_FRAC;   // arithmetic, rounds toward -inf
    return shifted[LANE_W-1:0];     // low lane bits kept
  endfunction

endpackage

`default_nettype wire

// ==== design/dct_rotate_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 3, DC pair scaling, pi/8 rotation, odd butterflies
module dct_rotate_stage (
  input  logic                aclk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  dct_pkg::lane_vec_t  in_block,
  output logic                out_valid,
  output dct_pkg::lane_vec_t  out_block
);

  logic signed [dct_pkg::LANE_W-1:0] dc_sum;    // x0 + x1
  logic signed [dct_pkg::LANE_W-1:0] dc_diff;   // x0 - x1
  logic signed [dct_pkg::LANE_W-1:0] dc0;       // halved sqrt(1/2) of sum
  logic signed [dct_pkg::LANE_W-1:0] dc1;       // same for diff
  logic signed [dct_pkg::LANE_W-1:0] rot_sum;   // lane 2 result
  logic signed [dct_pkg::LANE_W-1:0] rot_diff;  // lane 3 result

  ////////////////////////////////////////
  // DC pair
  ////////////////////////////////////////
  assign dc_sum  = in_block.x0 + in_block.x1;
  assign dc_diff = in_block.x0 - in_block.x1;
  assign dc0     = dct_pkg::mul_coef(dc_sum, dct_pkg::C_PI_4_H);
  assign dc1     = dct_pkg::mul_coef(dc_diff, dct_pkg::C_PI_4_H);

  // pi/8 rotation of lanes 2 and 3
  dct_rotator #(
    .K0 (dct_pkg::S_PI_8_H),
    .K1 (dct_pkg::C_PI_8_H)
  ) u_rot_pi_8 (
    .a      (in_block.x2),
    .b      (in_block.x3),
    .y_sum  (rot_sum),
    .y_diff (rot_diff)
  );

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  ////////////////////////////////////////
  // register
  ////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (in_valid) begin
      out_block.x0 <= dc0;
      out_block.x1 <= dc1;
      out_block.x2 <= rot_sum;
      out_block.x3 <= rot_diff;
      out_block.x4 <= in_block.x4 + in_block.x5;  // odd butterflies
      out_block.x5 <= in_block.x4 - in_block.x5;
      out_block.x6 <= in_block.x7 - in_block.x6;
      out_block.x7 <= in_block.x7 + in_block.x6;
    end
  end

endmodule

`default_nettype wire

// ==== design/dct_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

// plane rotation, two products per output
module dct_rotator #(
  parameter logic signed [dct_pkg::COEF_W-1:0] K0 = dct_pkg::S_PI_8_H,  // sine-like term
  parameter logic signed [dct_pkg::COEF_W-1:0] K1 = dct_pkg::C_PI_8_H   // cosine-like term
) (
  input  logic signed [dct_pkg::LANE_W-1:0] a,
  input  logic signed [dct_pkg::LANE_W-1:0] b,
  output logic signed [dct_pkg::LANE_W-1:0] y_sum,
  output logic signed [dct_pkg::LANE_W-1:0] y_diff
);

  logic signed [dct_pkg::LANE_W-1:0] a_k0;  // a scaled by K0
  logic signed [dct_pkg::LANE_W-1:0] a_k1;  // a scaled by K1
  logic signed [dct_pkg::LANE_W-1:0] b_k0;  // b scaled by K0
  logic signed [dct_pkg::LANE_W-1:0] b_k1;  // b scaled by K1

  ////////////////////////////////////////
  // products, each truncated on its own
  ////////////////////////////////////////
  assign a_k0 = dct_pkg::mul_coef(a, K0);
  assign a_k1 = dct_pkg::mul_coef(a, K1);
  assign b_k0 = dct_pkg::mul_coef(b, K0);
  assign b_k1 = dct_pkg::mul_coef(b, K1);

  ////////////////////////////////////////
  // combine
  ////////////////////////////////////////
  assign y_sum  = a_k0 + b_k1;  // a*K0 + b*K1
  assign y_diff = b_k0 - a_k1;  // b*K0 - a*K1, negation folded in

endmodule

`default_nettype wire

// ==== test/dct_model.svh ====
`ifndef DCT_MODEL_SVH
`define DCT_MODEL_SVH

`default_nettype none

// Q1.14 constants, rounded to nearest
localparam longint M_C4    = 11585;  // cos(pi/4)
localparam longint M_C4_H  = 5793;   // halved
localparam longint M_S8_H  = 3135;
localparam longint M_C8_H  = 7568;
localparam longint M_S16_H = 1598;
localparam longint M_C16_H = 8035;
localparam longint M_S3_H  = 4551;   // 3pi/16 pair
localparam longint M_C3_H  = 6811;

// lanes kept at 64 bits, so a wrap inside the DUT shows up as a mismatch
typedef struct packed {
  longint x0, x1, x2, x3, x4, x5, x6, x7;
} model_vec_t;

function automatic longint scale_q14(input longint a, input longint k);
  return (a * k) >>> 14;  // floor toward -inf
endfunction

////////////////////////////////////////
// one function per pipeline stage
////////////////////////////////////////
function automatic model_vec_t input_butterflies(input model_vec_t v);
  return '{v.x0 + v.x7, v.x1 + v.x6, v.x2 + v.x5, v.x3 + v.x4,
           v.x3 - v.x4, v.x2 - v.x5, v.x1 - v.x6, v.x0 - v.x7};
endfunction

function automatic model_vec_t even_odd_split(input model_vec_t v);
  return '{v.x0 + v.x3, v.x1 + v.x2, v.x1 - v.x2, v.x0 - v.x3,
           v.x4, scale_q14(v.x6 - v.x5, M_C4), scale_q14(v.x6 + v.x5, M_C4), v.x7};
endfunction

function automatic model_vec_t dc_and_pi8(input model_vec_t v);
  return '{scale_q14(v.x0 + v.x1, M_C4_H), scale_q14(v.x0 - v.x1, M_C4_H),
           scale_q14(v.x2, M_S8_H) + scale_q14(v.x3, M_C8_H),  // a=x2, b=x3
           scale_q14(v.x3, M_S8_H) - scale_q14(v.x2, M_C8_H),
           v.x4 + v.x5, v.x4 - v.x5, v.x7 - v.x6, v.x7 + v.x6};
endfunction

function automatic model_vec_t odd_rotations(input model_vec_t v);
  return '{v.x0, v.x1, v.x2, v.x3,
           scale_q14(v.x4, M_S16_H) + scale_q14(v.x7, M_C16_H),
           scale_q14(v.x5, M_C3_H) + scale_q14(v.x6, M_S3_H),   // cosine leads here
           scale_q14(v.x6, M_C3_H) - scale_q14(v.x5, M_S3_H),
           scale_q14(v.x7, M_S16_H) - scale_q14(v.x4, M_C16_H)};
endfunction

// whole transform of one input block
function automatic model_vec_t expected_dct(input dct_pkg::sample_vec_t s);
  model_vec_t v;
  v = '{longint'(s.x0), longint'(s.x1), longint'(s.x2), longint'(s.x3),
        longint'(s.x4), longint'(s.x5), longint'(s.x6), longint'(s.x7)};
  return odd_rotations(dc_and_pi8(even_odd_split(input_butterflies(v))));
endfunction

`default_nettype wire

`endif

// ==== test/tb_dct_1d.sv ====
`timescale 1ns/1ps
`include "dct_model.svh"
`default_nettype none

module tb_dct_1d;

  localparam int LATENCY     = 4;   // accept edge to output sample
  localparam int DRAIN_LIMIT = 40;  // cycles for the pipe to empty
  localparam int DC_VALS [5] = '{1000, -1234, 32767, -32768, 1};
  localparam logic [7:0] EXT_PATS [8] = '{8'h55, 8'haa, 8'h00, 8'hff,
                                         8'h0f, 8'hf0, 8'h33, 8'hcc};  // 1 = most negative

  typedef struct packed {
    model_vec_t block;  // expected lanes
    int         due;    // edge count when it must show
  } expect_t;

  logic                 aclk = 1'b0;
  logic                 rst_n;
  logic                 in_valid;
  dct_pkg::sample_vec_t in_block;
  logic                 out_valid;
  dct_pkg::lane_vec_t   out_block;

  expect_t            expect_q [$];  // blocks in flight, oldest first
  dct_pkg::lane_vec_t last_out;      // latest DUT output
  string              test_name = "none";
  int                 edge_count = 0;
  int                 out_count = 0;
  int                 error_count = 0;
  int                 check_count = 0;
  int                 errors_at_start = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int unsigned        seed_ret;

  dct_1d UUT (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_block  (in_block),
    .out_valid (out_valid),
    .out_block (out_block)
  );

  always #2 aclk = ~aclk;  // 4 ns period

  task automatic check_value(input string what, input longint expected, input longint actual);
    check_count++;
    if (expected !== actual) begin
      $display("error %s %s: expected %0d actual %0d", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_block(input model_vec_t e, input dct_pkg::lane_vec_t a);
    check_value("lane0", e.x0, longint'(a.x0));
    check_value("lane1", e.x1, longint'(a.x1));
    check_value("lane2", e.x2, longint'(a.x2));
    check_value("lane3", e.x3, longint'(a.x3));
    check_value("lane4", e.x4, longint'(a.x4));
    check_value("lane5", e.x5, longint'(a.x5));
    check_value("lane6", e.x6, longint'(a.x6));
    check_value("lane7", e.x7, longint'(a.x7));
  endtask

  ////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////
  task automatic record_inputs();
    expect_t entry;
    forever begin
      @(posedge aclk);
      if (rst_n && in_valid) begin  // block taken on this edge
        entry.block = expected_dct(in_block);
        entry.due   = edge_count + LATENCY;
        expect_q.push_back(entry);
      end
      edge_count <= edge_count + 1;
    end
  endtask

  task automatic watch_outputs();
    expect_t head;
    forever begin
      @(negedge aclk);  // outputs settled
      if (out_valid && expect_q.size() == 0) begin
        $display("test %s: out_valid high with no block in flight", test_name);
        error_count++;
      end else if (out_valid) begin
        head = expect_q.pop_front();
        check_value("arrival edge", longint'(head.due), longint'(edge_count));
        compare_block(head.block, out_block);
        last_out = out_block;
        out_count++;
      end
    end
  endtask

  ////////////////////////////////////////
  // drive and wait
  ////////////////////////////////////////
  task automatic send_block(input dct_pkg::sample_vec_t blk);
    @(posedge aclk);
    in_valid <= 1'b1;
    in_block <= blk;
  endtask

  task automatic drive_idle();
    @(posedge aclk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while (expect_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge aclk);
      cycles++;
    end
    if (expect_q.size() != 0) begin
      $display("timeout in test %s: %0d blocks never came out", test_name, expect_q.size());
      error_count++;
    end
  endtask

  function automatic dct_pkg::sample_vec_t extreme_block(input logic [7:0] pattern);
    dct_pkg::sample_vec_t s;
    for (int k = 0; k < 8; k++) begin
      s[127 - 16*k -: 16] = pattern[7 - k] ? 16'h8000 : 16'h7fff;  // bit 7 is x0
    end
    return s;
  endfunction

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
    out_count       = 0;
  endtask

  task automatic finish_test();
    int errs;
    errs = error_count - errors_at_start;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %s %s, %0d errors", test_name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic check_reset_quiet();
    start_test("reset_quiet");
    @(posedge aclk);
    @(negedge aclk);
    check_value("out_valid in reset", 0, longint'(out_valid));
    @(posedge aclk);
    rst_n <= 1'b1;  // second rising edge still in reset
    repeat (8) begin
      @(negedge aclk);
      check_value("out_valid after reset", 0, longint'(out_valid));
    end
    finish_test();
  endtask

  task automatic send_dc_blocks();
    longint dc_gain;
    start_test("dc_block");
    foreach (DC_VALS[i]) begin
      send_block({8{16'(DC_VALS[i])}});
      drive_idle();
      wait_drain();
      dc_gain = (longint'(DC_VALS[i]) * 8 * M_C4_H) >>> 14;  // 8v scaled by cos(pi/4)/2
      check_value("dc lane0", dc_gain, longint'(last_out.x0));
      for (int k = 1; k < 8; k++) begin
        check_value($sformatf("dc lane%0d", k), 0,
                    longint'($signed(last_out[191 - 24*k -: 24])));
      end
    end
    finish_test();
  endtask

  task automatic stream_back_to_back();
    start_test("back_to_back");
    repeat (200) send_block({$urandom(), $urandom(), $urandom(), $urandom()});
    drive_idle();
    wait_drain();
    check_value("output count", 200, longint'(out_count));
    finish_test();
  endtask

  task automatic stream_with_gaps();
    int sent;
    start_test("with_gaps");
    sent = 0;
    repeat (200) begin
      if ($urandom_range(1, 0) == 1) begin
        send_block({$urandom(), $urandom(), $urandom(), $urandom()});
        sent++;
      end else begin
        drive_idle();
      end
    end
    drive_idle();
    wait_drain();
    check_value("output count", longint'(sent), longint'(out_count));
    finish_test();
  endtask

  task automatic send_extremes();
    start_test("extremes");
    for (int i = 0; i < 8; i++) begin
      send_block(extreme_block(EXT_PATS[i]));
    end
    drive_idle();
    wait_drain();
    check_value("output count", 8, longint'(out_count));
    finish_test();
  endtask

  initial begin
    seed_ret = $urandom(396);  // seeds the run
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    in_block <= '0;
    fork
      record_inputs();
      watch_outputs();
    join_none
    check_reset_quiet();
    send_dc_blocks();
    stream_back_to_back();
    stream_with_gaps();
    send_extremes();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
